// ==== hw/tcdm_pkg.sv ====
// Shared widths and vector types of the TCDM subsystem.
// Words are 32 bits wide and each bank holds 256 words.
// Bank count and port count are module parameters, not package constants.

package tcdm_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  // Data word width in bits.
  localparam int unsigned DataWidth = 32;

  // Byte address width in bits.
  localparam int unsigned AddrWidth = 32;

  // One strobe bit per data byte.
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Address bits below the word.
  localparam int unsigned ByteOffset = $clog2(StrbWidth);

  // Word address inside one bank, 256 words deep.
  localparam int unsigned BankWordAddrWidth = 8;

  // ----------------------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------------------

  // Byte address as seen by a requesting port.
  typedef logic [AddrWidth-1:0] tcdm_addr_t;

  // One data word.
  typedef logic [DataWidth-1:0] tcdm_data_t;

  // Byte enables of one word.
  typedef logic [StrbWidth-1:0] tcdm_strb_t;

  // Word address inside one bank.
  typedef logic [BankWordAddrWidth-1:0] bank_addr_t;

endpackage

// ==== hw/tcdm_bank_if.sv ====
// Crossbar to bank bundle, one slot per bank.
// req is a single-cycle strobe, rdata follows the bank latency.

interface tcdm_bank_if #(
  parameter int unsigned NumBanks = 8
);

  import tcdm_pkg::*;

  // Request side, one bit or one word per bank.
  logic       [NumBanks-1:0] req;
  logic       [NumBanks-1:0] we;
  bank_addr_t [NumBanks-1:0] addr;
  tcdm_data_t [NumBanks-1:0] wdata;
  tcdm_strb_t [NumBanks-1:0] strb;

  // Read data coming back from the banks.
  tcdm_data_t [NumBanks-1:0] rdata;

  // Interconnect side.
  modport xbar (
    output req, we, addr, wdata, strb,
    input  rdata
  );

  // Memory side.
  modport bank (
    input  req, we, addr, wdata, strb,
    output rdata
  );

endinterface

// ==== hw/tcdm_addr_map.sv ====
// Maps a byte address to a bank and a word address inside that bank.
// NumBanks must be a power of two and at least 2.
// Rows whose index ends in 01 or 10 are rotated by half a row.
// Address bits above the bank word address are ignored.

module tcdm_addr_map #(
  parameter int unsigned NumPorts = 4,
  parameter int unsigned NumBanks = 8
) (
  input  tcdm_pkg::tcdm_addr_t [NumPorts-1:0]                       req_addr_i,
  output logic                 [NumPorts-1:0][$clog2(NumBanks)-1:0] bank_sel_o,
  output tcdm_pkg::bank_addr_t [NumPorts-1:0]                       bank_addr_o
);

  import tcdm_pkg::*;

  // Bank select width.
  localparam int unsigned SelWidth = $clog2(NumBanks);

  // The row index starts above the word offset within a row.
  localparam int unsigned RowLsb   = ByteOffset + SelWidth;
  localparam int unsigned RowWidth = AddrWidth - RowLsb;

  typedef logic [SelWidth-1:0] sel_t;
  typedef logic [RowWidth-1:0] row_t;

  // Rotation applied to swizzled rows.
  localparam sel_t HalfRow = sel_t'(NumBanks / 2);

  // Row index per port.
  row_t [NumPorts-1:0] row;

  // Word offset inside the row before the swizzle.
  sel_t [NumPorts-1:0] word_off;

  // High when the row of that port is rotated.
  logic [NumPorts-1:0] swizzle;

  // ----------------------------------------------------------------------
  // Interleaving and swizzle
  // ----------------------------------------------------------------------

  always_comb begin : proc_map
    for (int p = 0; p < NumPorts; p++) begin
      row[p]      = req_addr_i[p][AddrWidth-1:RowLsb];
      word_off[p] = req_addr_i[p][ByteOffset +: SelWidth];

      // Rows 01 and 10 of every group of four are shifted.
      swizzle[p]  = (row[p][1:0] == 2'b01) || (row[p][1:0] == 2'b10);

      // Adding half a row wraps inside the row by the select width.
      if (swizzle[p]) begin
        bank_sel_o[p] = word_off[p] + HalfRow;
      end else begin
        bank_sel_o[p] = word_off[p];
      end

      // Every bank holds one word of each row.
      bank_addr_o[p] = row[p][BankWordAddrWidth-1:0];
    end
  end

endmodule

// ==== hw/tcdm_req_xbar.sv ====
// Request crossbar with one round-robin arbiter per bank.
// Ready is combinational from valid and bank select, no spill register.
// A losing port must hold its request stable until it is accepted.

module tcdm_req_xbar #(
  parameter int unsigned NumPorts = 4,
  parameter int unsigned NumBanks = 8
) (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  logic                 [NumPorts-1:0]                       req_valid_i,
  input  logic                 [NumPorts-1:0]                       req_write_i,
  input  tcdm_pkg::tcdm_data_t [NumPorts-1:0]                       req_wdata_i,
  input  tcdm_pkg::tcdm_strb_t [NumPorts-1:0]                       req_strb_i,
  input  logic                 [NumPorts-1:0][$clog2(NumBanks)-1:0] bank_sel_i,
  input  tcdm_pkg::bank_addr_t [NumPorts-1:0]                       bank_addr_i,
  output logic                 [NumPorts-1:0]                       req_ready_o,
  output logic                 [NumPorts-1:0]                       accept_o,
  tcdm_bank_if.xbar                                                 bank
);

  localparam int unsigned SelWidth     = $clog2(NumBanks);
  localparam int unsigned PortIdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  typedef logic [SelWidth-1:0]     sel_t;
  typedef logic [PortIdxWidth-1:0] port_idx_t;

  // Ports that are valid and target a given bank.
  logic [NumBanks-1:0][NumPorts-1:0] cand;

  // Bank has a winner this cycle.
  logic [NumBanks-1:0] bank_gnt;

  // Winning port per bank, and the round-robin pointer.
  port_idx_t [NumBanks-1:0] bank_win;
  port_idx_t [NumBanks-1:0] rr_q;

  // Port won its bank.
  logic [NumPorts-1:0] port_gnt;

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------

  always_comb begin : proc_arbitrate
    int idx;
    cand     = '0;
    bank_gnt = '0;
    bank_win = '0;
    for (int b = 0; b < NumBanks; b++) begin
      for (int p = 0; p < NumPorts; p++) begin
        cand[b][p] = req_valid_i[p] && (bank_sel_i[p] == sel_t'(b));
      end
      // Search starts at the pointer and wraps around the ports.
      for (int k = 0; k < NumPorts; k++) begin
        idx = int'(rr_q[b]) + k;
        if (idx >= int'(NumPorts)) begin
          idx = idx - int'(NumPorts);
        end
        if (!bank_gnt[b] && cand[b][idx]) begin
          bank_gnt[b] = 1'b1;
          bank_win[b] = port_idx_t'(idx);
        end
      end
    end
  end

  // A port is granted when its bank picked it.
  always_comb begin : proc_port_gnt
    for (int p = 0; p < NumPorts; p++) begin
      port_gnt[p] = req_valid_i[p] && bank_gnt[bank_sel_i[p]] &&
                    (bank_win[bank_sel_i[p]] == port_idx_t'(p));
    end
  end

  assign req_ready_o = port_gnt;

  // Handshake completes on valid and ready.
  assign accept_o = port_gnt & req_valid_i;

  // Pointer moves to one past the winner on a grant.
  always_ff @(posedge clk_i) begin : proc_rr
    if (!rst_n_i) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        if (bank_gnt[b]) begin
          if (bank_win[b] == port_idx_t'(NumPorts - 1)) begin
            rr_q[b] <= '0;
          end else begin
            rr_q[b] <= bank_win[b] + 1'b1;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Routing onto the banks
  // ----------------------------------------------------------------------

  // The winner's fields drive the bank slot, idle slots see port 0.
  always_comb begin : proc_route
    for (int b = 0; b < NumBanks; b++) begin
      bank.req[b]   = bank_gnt[b];
      bank.we[b]    = req_write_i[bank_win[b]];
      bank.addr[b]  = bank_addr_i[bank_win[b]];
      bank.wdata[b] = req_wdata_i[bank_win[b]];
      bank.strb[b]  = req_strb_i[bank_win[b]];
    end
  end

endmodule

// ==== hw/tcdm_bank_array.sv ====
// Single-ported word banks, 256 words each, byte strobed writes.
// Read data appears BankLatency edges after the strobe, BankLatency >= 1.
// Memory contents are not cleared by reset.

module tcdm_bank_array #(
  parameter int unsigned NumBanks    = 8,
  parameter int unsigned BankLatency = 1
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  tcdm_bank_if.bank bank
);

  import tcdm_pkg::*;

  localparam int unsigned BankWords = 2 ** BankWordAddrWidth;

  // Word storage of every bank.
  tcdm_data_t mem_q [NumBanks][BankWords];

  // Read pipeline data and per-stage read marker.
  tcdm_data_t rdata_q [NumBanks][BankLatency];
  logic [NumBanks-1:0][BankLatency-1:0] rd_vld_q;

  // ----------------------------------------------------------------------
  // Memory and read pipeline
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i) begin : proc_mem
    for (int b = 0; b < NumBanks; b++) begin
      if (bank.req[b]) begin
        if (bank.we[b]) begin
          // Only enabled bytes are written.
          for (int i = 0; i < StrbWidth; i++) begin
            if (bank.strb[b][i]) begin
              mem_q[b][bank.addr[b]][8*i +: 8] <= bank.wdata[b][8*i +: 8];
            end
          end
        end else begin
          rdata_q[b][0] <= mem_q[b][bank.addr[b]];
        end
      end
      // A stage only loads when a read sits in front of it.
      for (int s = 1; s < BankLatency; s++) begin
        if (rd_vld_q[b][s-1]) begin
          rdata_q[b][s] <= rdata_q[b][s-1];
        end
      end
    end
  end

  // Read markers travel alongside the data.
  always_ff @(posedge clk_i) begin : proc_rd_vld
    if (!rst_n_i) begin
      rd_vld_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        rd_vld_q[b][0] <= bank.req[b] && !bank.we[b];
        for (int s = 1; s < BankLatency; s++) begin
          rd_vld_q[b][s] <= rd_vld_q[b][s-1];
        end
      end
    end
  end

  // Output is zero unless a read reaches the last stage.
  always_comb begin : proc_rdata
    for (int b = 0; b < NumBanks; b++) begin
      bank.rdata[b] = rd_vld_q[b][BankLatency-1] ? rdata_q[b][BankLatency-1] : '0;
    end
  end

endmodule

// ==== hw/tcdm_rsp_return.sv ====
// Fixed latency response return.
// Each port remembers accept and bank select for BankLatency cycles,
// then picks that bank's read data. Responses cannot be stalled.

module tcdm_rsp_return #(
  parameter int unsigned NumPorts    = 4,
  parameter int unsigned NumBanks    = 8,
  parameter int unsigned BankLatency = 1
) (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  logic                 [NumPorts-1:0]                       accept_i,
  input  logic                 [NumPorts-1:0][$clog2(NumBanks)-1:0] bank_sel_i,
  tcdm_bank_if.xbar                                                 bank,
  output logic                 [NumPorts-1:0]                       rsp_valid_o,
  output tcdm_pkg::tcdm_data_t [NumPorts-1:0]                       rsp_rdata_o
);

  localparam int unsigned SelWidth = $clog2(NumBanks);

  typedef logic [SelWidth-1:0] sel_t;

  // Accept history, one bit per stage.
  logic [NumPorts-1:0][BankLatency-1:0] vld_q;

  // Bank select history.
  sel_t sel_q [NumPorts][BankLatency];

  // ----------------------------------------------------------------------
  // Shift registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i) begin : proc_vld
    if (!rst_n_i) begin
      vld_q <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        vld_q[p][0] <= accept_i[p];
        for (int s = 1; s < BankLatency; s++) begin
          vld_q[p][s] <= vld_q[p][s-1];
        end
      end
    end
  end

  // Select moves along with its accept bit only.
  always_ff @(posedge clk_i) begin : proc_sel
    for (int p = 0; p < NumPorts; p++) begin
      if (accept_i[p]) begin
        sel_q[p][0] <= bank_sel_i[p];
      end
      for (int s = 1; s < BankLatency; s++) begin
        if (vld_q[p][s-1]) begin
          sel_q[p][s] <= sel_q[p][s-1];
        end
      end
    end
  end

  // Last stage steers the bank read data to the port.
  always_comb begin : proc_rsp
    for (int p = 0; p < NumPorts; p++) begin
      rsp_valid_o[p] = vld_q[p][BankLatency-1];
      rsp_rdata_o[p] = bank.rdata[sel_q[p][BankLatency-1]];
    end
  end

endmodule

// ==== hw/tcdm_subsystem.sv ====
// TCDM subsystem top with a logarithmic crossbar.
// NumBanks must be a power of two and at least 2, BankLatency >= 1.
// Every accepted request answers exactly BankLatency cycles later.
// A port that is not ready must hold its request stable.

module tcdm_subsystem #(
  parameter int unsigned NumPorts    = 4,
  parameter int unsigned NumBanks    = 8,
  parameter int unsigned BankLatency = 1
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Request channel.
  input  logic                 [NumPorts-1:0]  req_valid_i,
  output logic                 [NumPorts-1:0]  req_ready_o,
  input  tcdm_pkg::tcdm_addr_t [NumPorts-1:0]  req_addr_i,
  input  logic                 [NumPorts-1:0]  req_write_i,
  input  tcdm_pkg::tcdm_data_t [NumPorts-1:0]  req_wdata_i,
  input  tcdm_pkg::tcdm_strb_t [NumPorts-1:0]  req_strb_i,
  // Response channel, no back-pressure.
  output logic                 [NumPorts-1:0]  rsp_valid_o,
  output tcdm_pkg::tcdm_data_t [NumPorts-1:0]  rsp_rdata_o
);

  import tcdm_pkg::*;

  localparam int unsigned SelWidth = $clog2(NumBanks);

  // Address map outputs, shared by crossbar and response return.
  logic       [NumPorts-1:0][SelWidth-1:0] bank_sel;
  bank_addr_t [NumPorts-1:0]               bank_addr;

  // Granted requests.
  logic [NumPorts-1:0] accept;

  // Crossbar to bank bundle.
  tcdm_bank_if #(.NumBanks(NumBanks)) bank_if ();

  // ----------------------------------------------------------------------
  // Request path
  // ----------------------------------------------------------------------

  tcdm_addr_map #(
    .NumPorts (NumPorts),
    .NumBanks (NumBanks)
  ) i_addr_map (
    .req_addr_i  (req_addr_i),
    .bank_sel_o  (bank_sel),
    .bank_addr_o (bank_addr)
  );

  tcdm_req_xbar #(
    .NumPorts (NumPorts),
    .NumBanks (NumBanks)
  ) i_req_xbar (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_wdata_i (req_wdata_i),
    .req_strb_i  (req_strb_i),
    .bank_sel_i  (bank_sel),
    .bank_addr_i (bank_addr),
    .req_ready_o (req_ready_o),
    .accept_o    (accept),
    .bank        (bank_if.xbar)
  );

  // ----------------------------------------------------------------------
  // Banks and response path
  // ----------------------------------------------------------------------

  tcdm_bank_array #(
    .NumBanks    (NumBanks),
    .BankLatency (BankLatency)
  ) i_bank_array (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bank    (bank_if.bank)
  );

  tcdm_rsp_return #(
    .NumPorts    (NumPorts),
    .NumBanks    (NumBanks),
    .BankLatency (BankLatency)
  ) i_rsp_return (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .accept_i    (accept),
    .bank_sel_i  (bank_sel),
    .bank        (bank_if.xbar),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

endmodule

// ==== verif/tcdm_subsystem_checker.sv ====
// Concurrent checks on the TCDM request handshake and response timing.
// Bank selection is recomputed from the byte addresses with the row swizzle.
// Bound into tcdm_subsystem, fail_cnt counts every failed assertion.

module tcdm_subsystem_checker #(
  parameter int unsigned NumPorts    = 4,
  parameter int unsigned NumBanks    = 8,
  parameter int unsigned BankLatency = 1
) (
  input logic                                 clk_i,
  input logic                                 rst_n_i,
  input logic                 [NumPorts-1:0]  req_valid_i,
  input logic                 [NumPorts-1:0]  req_ready_o,
  input tcdm_pkg::tcdm_addr_t [NumPorts-1:0]  req_addr_i,
  input logic                 [NumPorts-1:0]  rsp_valid_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import tcdm_pkg::*;

  // Failed assertions so far.
  int unsigned fail_cnt = 0;

  logic [NumPorts-1:0] accept;
  logic                bank_clash;

  assign accept = req_valid_i & req_ready_o;

  // Word offset in the row, rotated by half a row in rows 01 and 10.
  function automatic int unsigned bank_of(input tcdm_addr_t addr);
    int unsigned row;
    int unsigned off;
    row = addr / (StrbWidth * NumBanks);
    off = (addr / StrbWidth) % NumBanks;
    if ((row % 4 == 1) || (row % 4 == 2)) begin
      off = (off + NumBanks / 2) % NumBanks;
    end
    return off;
  endfunction

  // Two accepted ports on one bank in the same cycle.
  always_comb begin : find_clash
    bank_clash = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int q = p + 1; q < NumPorts; q++) begin
        if (accept[p] && accept[q] && (bank_of(req_addr_i[p]) == bank_of(req_addr_i[q]))) begin
          bank_clash = 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_ready_o & ~req_valid_i) == '0)
  else begin
    fail_cnt++;
    $error("req_ready_o raised without req_valid_i");
  end

  no_bank_clash: assert property (@(posedge clk_i) disable iff (!rst_n_i) !bank_clash)
  else begin
    fail_cnt++;
    $error("two ports accepted on one bank in the same cycle");
  end

  // Response comes exactly BankLatency cycles after the accept, and only then.
  for (genvar p = 0; p < NumPorts; p++) begin : g_port
    accept_gets_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(accept[p], BankLatency) |-> rsp_valid_o[p])
    else begin
      fail_cnt++;
      $error("port %0d accept without response after the bank latency", p);
    end

    rsp_has_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_valid_o[p] |-> $past(accept[p], BankLatency))
    else begin
      fail_cnt++;
      $error("port %0d response without an earlier accept", p);
    end
  end

endmodule

// ==== verif/tcdm_subsystem_tb.sv ====
// Testbench of the TCDM subsystem, 4 ports, 8 banks, bank latency 2.
// Addresses stay inside the 8 KiB that the banks can hold without aliasing.
// Expected responses come from a shadow memory updated at each accept.
// All words are written once before any read, bank contents are not reset.

module tcdm_subsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import tcdm_pkg::*;

  localparam int unsigned NumPorts    = 4;
  localparam int unsigned NumBanks    = 8;
  localparam int unsigned BankLatency = 2;

  // Words reachable without aliasing, and request counts per phase.
  localparam int unsigned ShadowWords = NumBanks * (2 ** BankWordAddrWidth);
  localparam int unsigned RawCount    = 24;
  localparam int unsigned RrCount     = 8;
  localparam int unsigned RrBank      = 3;
  localparam int unsigned StreamCount = 16;
  localparam int unsigned PairCount   = 6;
  localparam int unsigned TotalReqs   = ShadowWords + PairCount +
                                        NumPorts * (2 * RawCount + RrCount + StreamCount);
  localparam int unsigned TimeoutCycles = TotalReqs * NumPorts * 20 + 1000;

  typedef struct packed {
    logic       write;
    tcdm_addr_t addr;
    tcdm_data_t wdata;
    tcdm_strb_t strb;
  } req_t;

  // One expected response, due in a given cycle.
  typedef struct packed {
    logic [31:0] due;
    logic        is_read;
    tcdm_data_t  data;
  } exp_t;

  logic                      clk_i       = 1'b0;
  logic                      rst_n_i     = 1'b0;
  logic       [NumPorts-1:0] req_valid_i = '0;
  logic       [NumPorts-1:0] req_ready_o;
  tcdm_addr_t [NumPorts-1:0] req_addr_i  = '0;
  logic       [NumPorts-1:0] req_write_i = '0;
  tcdm_data_t [NumPorts-1:0] req_wdata_i = '0;
  tcdm_strb_t [NumPorts-1:0] req_strb_i  = '0;
  logic       [NumPorts-1:0] rsp_valid_o;
  tcdm_data_t [NumPorts-1:0] rsp_rdata_o;

  // Stimulus queues, expected responses and the reference memory.
  req_t        pend_q [NumPorts][$];
  exp_t        exp_q  [NumPorts][$];
  tcdm_data_t  shadow [ShadowWords];
  logic [31:0] rng = 32'h1951_2078;

  // Monitor bookkeeping.
  int unsigned cycle = 0;
  int unsigned acc_cycle [NumPorts];
  int unsigned wait_cnt  [NumPorts];
  int unsigned stall_cnt = 0;
  int          grant_log [$];
  logic        log_grants = 1'b0;

  // Error counters, one per kind of check.
  int unsigned valid_errs = 0;
  int unsigned data_errs  = 0;
  int unsigned wait_errs  = 0;
  int unsigned order_errs = 0;

  always #5 clk_i = ~clk_i;

  tcdm_subsystem #(
    .NumPorts    (NumPorts),
    .NumBanks    (NumBanks),
    .BankLatency (BankLatency)
  ) i_tcdm_subsystem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_write_i (req_write_i),
    .req_wdata_i (req_wdata_i),
    .req_strb_i  (req_strb_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

  bind tcdm_subsystem tcdm_subsystem_checker #(
    .NumPorts    (NumPorts),
    .NumBanks    (NumBanks),
    .BankLatency (BankLatency)
  ) i_checker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .rsp_valid_o (rsp_valid_o)
  );

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bank of an address, rows 01 and 10 rotated by half a row.
  function automatic int unsigned bank_of(input tcdm_addr_t addr);
    int unsigned row;
    int unsigned off;
    row = addr / (StrbWidth * NumBanks);
    off = (addr / StrbWidth) % NumBanks;
    if ((row % 4 == 1) || (row % 4 == 2)) begin
      off = (off + NumBanks / 2) % NumBanks;
    end
    return off;
  endfunction

  // Address of a row and bank, the rotation is its own inverse.
  function automatic tcdm_addr_t addr_for(input int unsigned row, input int unsigned bank);
    int unsigned off;
    off = bank;
    if ((row % 4 == 1) || (row % 4 == 2)) begin
      off = (bank + NumBanks / 2) % NumBanks;
    end
    return tcdm_addr_t'((row * NumBanks + off) * StrbWidth);
  endfunction

  // Initial word content, a hash of the full address.
  function automatic tcdm_data_t fill_word(input tcdm_addr_t addr);
    return (addr * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
  endfunction

  task automatic check_valid(input int port, input logic exp, input logic act);
    if (act !== exp) begin
      valid_errs++;
      $display("FAILED %0t rsp_valid_o[%0d] expected %b actual %b", $time, port, exp, act);
    end
  endtask

  task automatic check_data(input int port, input tcdm_data_t exp, input tcdm_data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("FAILED %0t rsp_rdata_o[%0d] expected %h actual %h", $time, port, exp, act);
    end
  endtask

  // ----------------------------------------------------------------------
  // Compare process
  // ----------------------------------------------------------------------

  // Values read here are those of the cycle that ends at this edge.
  always @(posedge clk_i) begin : compare_rsp
    exp_t        e;
    int unsigned w;
    cycle = cycle + 1;
    for (int p = 0; p < NumPorts; p++) begin
      if (!rst_n_i) begin
        // The first cycle precedes any reset edge.
        if (cycle > 1) begin
          check_valid(p, 1'b0, rsp_valid_o[p]);
        end
      end else begin
        if ((exp_q[p].size() > 0) && (exp_q[p][0].due == cycle)) begin
          e = exp_q[p].pop_front();
          check_valid(p, 1'b1, rsp_valid_o[p]);
          if (e.is_read) begin
            check_data(p, e.data, rsp_rdata_o[p]);
          end
        end else begin
          check_valid(p, 1'b0, rsp_valid_o[p]);
        end
        if (req_valid_i[p] && req_ready_o[p]) begin
          // Round robin serves a waiting port within NumPorts cycles.
          if (wait_cnt[p] >= NumPorts) begin
            wait_errs++;
            $display("Port %0d waited %0d cycles for a grant at %0t", p, wait_cnt[p], $time);
          end
          wait_cnt[p]  = 0;
          acc_cycle[p] = cycle;
          if (log_grants) begin
            grant_log.push_back(p);
          end
          w         = (req_addr_i[p] / StrbWidth) % ShadowWords;
          e.due     = cycle + BankLatency;
          e.is_read = !req_write_i[p];
          e.data    = shadow[w];
          exp_q[p].push_back(e);
          if (req_write_i[p]) begin
            for (int i = 0; i < StrbWidth; i++) begin
              if (req_strb_i[p][i]) begin
                shadow[w][8*i +: 8] = req_wdata_i[p][8*i +: 8];
              end
            end
          end
        end else if (req_valid_i[p]) begin
          wait_cnt[p] = wait_cnt[p] + 1;
          stall_cnt   = stall_cnt + 1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  // Feeds the queued requests and holds each one until it is accepted.
  task automatic drive_until_idle();
    req_t                r;
    logic [NumPorts-1:0] nxt_valid;
    nxt_valid = '1;
    while (|nxt_valid) begin
      @(posedge clk_i);
      nxt_valid = req_valid_i;
      for (int p = 0; p < NumPorts; p++) begin
        if (!req_valid_i[p] || req_ready_o[p]) begin
          nxt_valid[p] = 1'b0;
          if (pend_q[p].size() > 0) begin
            r = pend_q[p].pop_front();
            nxt_valid[p]   = 1'b1;
            req_addr_i[p]  <= r.addr;
            req_write_i[p] <= r.write;
            req_wdata_i[p] <= r.wdata;
            req_strb_i[p]  <= r.strb;
          end
        end
      end
      req_valid_i <= nxt_valid;
    end
    // Fixed latency bounds the drain.
    repeat (BankLatency + 2) @(posedge clk_i);
  endtask

  // Ports 0 and 1 meet in one cycle only when their banks differ.
  task automatic pair_test(input tcdm_addr_t a0, input tcdm_addr_t a1);
    req_t r;
    logic apart;
    r.write = 1'b0;
    r.addr  = a0;
    r.wdata = '0;
    r.strb  = '0;
    pend_q[0].push_back(r);
    r.addr = a1;
    pend_q[1].push_back(r);
    drive_until_idle();
    apart = (bank_of(a0) != bank_of(a1));
    if ((acc_cycle[0] == acc_cycle[1]) != apart) begin
      order_errs++;
      $display("Reads of %h and %h were accepted in cycles %0d and %0d, wrong for banks %0d, %0d",
               a0, a1, acc_cycle[0], acc_cycle[1], bank_of(a0), bank_of(a1));
    end
  endtask

  initial begin : run_tests
    req_t        r;
    tcdm_addr_t  raw_addr [NumPorts][RawCount];
    int unsigned stalls;
    int unsigned fails;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Every word gets a known value first.
    for (int w = 0; w < ShadowWords; w++) begin
      r.write = 1'b1;
      r.addr  = tcdm_addr_t'(w * StrbWidth);
      r.wdata = fill_word(r.addr);
      r.strb  = '1;
      pend_q[w % NumPorts].push_back(r);
    end
    drive_until_idle();

    // Random partial writes, then reads of the same words.
    for (int p = 0; p < NumPorts; p++) begin
      for (int i = 0; i < RawCount; i++) begin
        rng            = xorshift32(rng);
        raw_addr[p][i] = tcdm_addr_t'((rng % ShadowWords) * StrbWidth);
        r.write        = 1'b1;
        r.addr         = raw_addr[p][i];
        rng            = xorshift32(rng);
        r.wdata        = rng;
        rng            = xorshift32(rng);
        r.strb         = rng[StrbWidth-1:0];
        pend_q[p].push_back(r);
      end
    end
    for (int p = 0; p < NumPorts; p++) begin
      for (int i = 0; i < RawCount; i++) begin
        r.write = 1'b0;
        r.addr  = raw_addr[p][i];
        pend_q[p].push_back(r);
      end
    end
    drive_until_idle();

    // Row 01 moves offset 0 away from bank 0, the other pairs collide.
    pair_test(32'h0000_0000, 32'h0000_0020);
    pair_test(32'h0000_0000, 32'h0000_0030);
    pair_test(32'h0000_0040, 32'h0000_0070);

    // All ports stream into one bank.
    log_grants = 1'b1;
    grant_log.delete();
    for (int p = 0; p < NumPorts; p++) begin
      for (int i = 0; i < RrCount; i++) begin
        r.write = 1'b0;
        r.addr  = addr_for(p * RrCount + i, RrBank);
        pend_q[p].push_back(r);
      end
    end
    drive_until_idle();
    log_grants = 1'b0;
    for (int i = 1; i < grant_log.size(); i++) begin
      if (grant_log[i] != (grant_log[i-1] + 1) % NumPorts) begin
        order_errs++;
        $display("Grant %0d went to port %0d after port %0d", i, grant_log[i], grant_log[i-1]);
      end
    end

    // Each port reads its own bank every cycle.
    stalls = stall_cnt;
    for (int p = 0; p < NumPorts; p++) begin
      for (int i = 0; i < StreamCount; i++) begin
        r.write = 1'b0;
        r.addr  = addr_for(i, 2 * p);
        pend_q[p].push_back(r);
      end
    end
    drive_until_idle();
    if (stall_cnt != stalls) begin
      order_errs++;
      $display("Streaming ports on private banks were stalled %0d times", stall_cnt - stalls);
    end

    fails = i_tcdm_subsystem.i_checker.fail_cnt;
    $display("Errors: valid %0d, data %0d, wait %0d, order %0d, assertion %0d",
             valid_errs, data_errs, wait_errs, order_errs, fails);
    if ((valid_errs + data_errs + wait_errs + order_errs + fails) == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Ends a run that stops making progress.
  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Timeout after %0d cycles, the requests did not complete", TimeoutCycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== files.f ====
hw/tcdm_pkg.sv
hw/tcdm_bank_if.sv
hw/tcdm_addr_map.sv
hw/tcdm_req_xbar.sv
hw/tcdm_bank_array.sv
hw/tcdm_rsp_return.sv
hw/tcdm_subsystem.sv
verif/tcdm_subsystem_checker.sv
verif/tcdm_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the TCDM testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tcdm_subsystem_tb \
  -f files.f --Mdir obj_dir -o sim_tcdm

out=$(./obj_dir/sim_tcdm +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
  exit 0
else
  exit 1
fi
